// ==== rtl/frame_check_sequence.sv ====
// Ethernet CRC-32
module frame_check_sequence (
    input  logic              clock,
    input  logic              rst_n,
    input  udp_tx_pkg::byte_t data,
    input  logic              data_valid,
    input  logic              data_last,
    output logic [31:0]       fcs,
    output logic              fcs_valid
);
    logic [31:0] crc;
    logic [31:0] crc_next;

    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] d);
        logic [31:0] c;
        c = crc_in ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);  // Reflected 0x04C11DB7
        end
        return c;
    endfunction

    assign crc_next = crc_byte(crc, data);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            crc       <= '1;
            fcs       <= '0;
            fcs_valid <= 1'b0;
        end else begin
            fcs_valid <= 1'b0;
            if (data_valid) begin
                if (data_last) begin
                    fcs       <= ~crc_next;  // Byte 0 goes out first
                    fcs_valid <= 1'b1;
                    crc       <= '1;
                end else begin
                    crc <= crc_next;
                end
            end
        end
    end

endmodule

// ==== rtl/frame_generator.sv ====
// Ethernet frame generator
module frame_generator (
    input  logic                      clock,
    input  logic                      rst_n,
    input  udp_tx_pkg::mac_addr_t     mac_source,
    input  udp_tx_pkg::ipv4_addr_t    ipv4_source,
    input  logic                      frame_pending,
    output logic                      frame_done,
    input  udp_tx_pkg::mac_addr_t     mac_destination,
    input  udp_tx_pkg::ipv4_addr_t    ipv4_destination,
    input  udp_tx_pkg::udp_port_t     udp_destination,
    input  udp_tx_pkg::payload_len_t  payload_length,
    output udp_tx_pkg::payload_addr_t read_address,
    input  udp_tx_pkg::byte_t         read_data,
    output udp_tx_pkg::byte_t         checksum_data,
    output logic                      checksum_valid,
    output logic                      checksum_last,
    input  logic [15:0]               checksum_result,
    input  logic                      checksum_result_valid,
    output udp_tx_pkg::byte_t         fcs_data,
    output logic                      fcs_data_valid,
    output logic                      fcs_data_last,
    input  logic [31:0]               fcs,
    input  logic                      fcs_valid,
    output udp_tx_pkg::byte_t         tx_data,
    output logic                      tx_last,
    output logic                      tx_valid,
    input  logic                      tx_ready
);
    import udp_tx_pkg::*;

    generator_state_e          state;
    logic [6:0]                count;           // Frame position, FCS byte in FCS
    logic [15:0]               identification;
    logic [15:0]               header_checksum;
    logic                      fcs_held;
    logic [15:0]               ipv4_total_length;
    logic [15:0]               udp_length;
    logic [6:0]                payload_end;
    logic [HEADER_BYTES*8-1:0] header;
    logic [5:0]                header_index;
    byte_t                     header_byte;
    logic                      transfer;

    ////////////////////////////////////////
    // Header byte select
    ////////////////////////////////////////
    assign ipv4_total_length = 16'd28 + {9'd0, payload_length};  // IPv4 + UDP headers
    assign udp_length        = 16'd8 + {9'd0, payload_length};

    assign header = {mac_destination, mac_source, ETHERTYPE_IPV4,
                     8'h45, 8'h00, ipv4_total_length, identification,
                     IPV4_FLAGS_DF, IPV4_TTL, IPV4_PROTOCOL_UDP, header_checksum,
                     ipv4_source, ipv4_destination,
                     UDP_SOURCE_PORT, udp_destination, udp_length, 16'h0000};

    always_comb begin
        case (state)
            GEN_CHECKSUM: header_index = count[5:0] + 6'd14;  // IPv4 part only
            GEN_HEADER:   header_index = count[5:0];
            default:      header_index = '0;
        endcase
    end

    assign header_byte = header[HEADER_BYTES*8-1 - 8*header_index -: 8];

    assign checksum_data  = header_byte;
    assign checksum_valid = (state == GEN_CHECKSUM) && (count < 7'd20);
    assign checksum_last  = (state == GEN_CHECKSUM) && (count == 7'd19);

    ////////////////////////////////////////
    // Output stream
    ////////////////////////////////////////
    assign read_address = count[5:0] - 6'(HEADER_BYTES);
    assign payload_end  = 7'(HEADER_BYTES - 1) + payload_length;

    always_comb begin
        case (state)
            GEN_HEADER:  tx_data = header_byte;
            GEN_PAYLOAD: tx_data = read_data;
            GEN_FCS:     tx_data = fcs[8*count[1:0] +: 8];
            default:     tx_data = '0;  // Pad
        endcase
    end

    assign tx_valid   = (state == GEN_HEADER) || (state == GEN_PAYLOAD) ||
                        (state == GEN_PAD) || (state == GEN_FCS && fcs_held);
    assign tx_last    = (state == GEN_FCS) && fcs_held && (count == 7'd3);
    assign transfer   = tx_valid && tx_ready;
    assign frame_done = transfer && tx_last;

    // Last byte before the FCS, at or past the minimum length
    assign fcs_data_last = (state == GEN_PAD && count == 7'(MIN_FRAME_BYTES - 1)) ||
                           (state == GEN_PAYLOAD && count == payload_end &&
                            count >= 7'(MIN_FRAME_BYTES - 1));
    assign fcs_data       = tx_data;
    assign fcs_data_valid = transfer && (state != GEN_FCS);

    // Zero while the checksum runs
    always_ff @(posedge clock) begin
        if (checksum_result_valid) begin
            header_checksum <= checksum_result;
        end else if (state == GEN_IDLE) begin
            header_checksum <= '0;
        end
    end

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state          <= GEN_IDLE;
            count          <= '0;
            identification <= '0;
            fcs_held       <= 1'b0;
        end else begin
            case (state)
                GEN_IDLE: begin
                    if (frame_pending) begin
                        state <= GEN_CHECKSUM;
                        count <= '0;
                    end
                end
                GEN_CHECKSUM: begin
                    if (checksum_valid) begin
                        count <= count + 1'b1;
                    end
                    if (checksum_result_valid) begin
                        state <= GEN_HEADER;
                        count <= '0;
                    end
                end
                GEN_HEADER: begin
                    if (transfer) begin
                        count <= count + 1'b1;
                        if (count == 7'(HEADER_BYTES - 1)) begin
                            state <= (payload_length != '0) ? GEN_PAYLOAD : GEN_PAD;
                        end
                    end
                end
                GEN_PAYLOAD, GEN_PAD: begin
                    if (transfer) begin
                        count <= count + 1'b1;
                        if (fcs_data_last) begin
                            state <= GEN_FCS;
                            count <= '0;
                        end else if (state == GEN_PAYLOAD && count == payload_end) begin
                            state <= GEN_PAD;  // Short frame
                        end
                    end
                end
                GEN_FCS: begin
                    if (fcs_valid) begin
                        fcs_held <= 1'b1;
                    end
                    if (transfer) begin
                        count <= count + 1'b1;
                    end
                    if (frame_done) begin
                        state          <= GEN_IDLE;
                        fcs_held       <= 1'b0;
                        identification <= identification + 1'b1;
                    end
                end
                default: state <= GEN_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/ipv4_checksum.sv ====
// Internet checksum
module ipv4_checksum (
    input  logic              clock,
    input  logic              rst_n,
    input  udp_tx_pkg::byte_t data,
    input  logic              data_valid,
    input  logic              data_last,
    output logic [15:0]       result,
    output logic              result_valid
);
    logic [15:0] accumulator;
    logic [7:0]  high_byte;
    logic        byte_held;     // High half of a word waiting
    logic [15:0] word;
    logic [16:0] sum;
    logic [15:0] folded;

    // Odd trailing byte is padded with zero
    assign word   = byte_held ? {high_byte, data} : {data, 8'h00};
    assign sum    = {1'b0, accumulator} + {1'b0, word};
    assign folded = sum[15:0] + {15'd0, sum[16]};  // End-around carry

    always_ff @(posedge clock) begin
        if (data_valid && !byte_held) begin
            high_byte <= data;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            accumulator  <= '0;
            byte_held    <= 1'b0;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (data_valid) begin
                if (data_last) begin
                    result       <= ~folded;
                    result_valid <= 1'b1;
                    accumulator  <= '0;
                    byte_held    <= 1'b0;
                end else if (byte_held) begin
                    accumulator <= folded;
                    byte_held   <= 1'b0;
                end else begin
                    byte_held <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/payload_buffer.sv ====
// Payload RAM
module payload_buffer (
    input  logic                      clock,
    input  logic                      write_enable,
    input  udp_tx_pkg::payload_addr_t write_address,
    input  udp_tx_pkg::byte_t         write_data,
    input  udp_tx_pkg::payload_addr_t read_address,
    output udp_tx_pkg::byte_t         read_data
);
    import udp_tx_pkg::*;

    byte_t memory [MAX_PAYLOAD];

    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write_address] <= write_data;
        end
    end

    // Combinational read, one byte per cycle out of the generator
    assign read_data = memory[read_address];

endmodule

// ==== rtl/tx_request_capture.sv ====
// Transmit request capture
module tx_request_capture (
    input  logic                      clock,
    input  logic                      rst_n,
    input  udp_tx_pkg::byte_t         in_data,
    input  logic                      in_last,
    input  logic                      in_valid,
    output logic                      in_ready,
    output logic                      write_enable,
    output udp_tx_pkg::payload_addr_t write_address,
    output udp_tx_pkg::byte_t         write_data,
    output logic                      frame_pending,
    input  logic                      frame_done,
    output udp_tx_pkg::mac_addr_t     mac_destination,
    output udp_tx_pkg::ipv4_addr_t    ipv4_destination,
    output udp_tx_pkg::udp_port_t     udp_destination,
    output udp_tx_pkg::payload_len_t  payload_length
);
    import udp_tx_pkg::*;

    capture_state_e                state;
    logic [3:0]                    descriptor_count;
    logic [DESCRIPTOR_BYTES*8-1:0] descriptor;
    payload_len_t                  length;
    logic                          accept;

    assign in_ready      = (state != CAPTURE_HOLD);
    assign accept        = in_valid && in_ready;
    assign frame_pending = (state == CAPTURE_HOLD);

    // Bytes past the cap are taken and dropped
    assign write_enable  = accept && (state == CAPTURE_PAYLOAD) &&
                           (length < payload_len_t'(MAX_PAYLOAD));
    assign write_address = length[5:0];
    assign write_data    = in_data;

    assign {mac_destination, ipv4_destination, udp_destination} = descriptor;
    assign payload_length = length;

    // MSB first, so shift left
    always_ff @(posedge clock) begin
        if (accept && state == CAPTURE_DESCRIPTOR) begin
            descriptor <= {descriptor[DESCRIPTOR_BYTES*8-9:0], in_data};
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state            <= CAPTURE_DESCRIPTOR;
            descriptor_count <= '0;
            length           <= '0;
        end else begin
            case (state)
                CAPTURE_DESCRIPTOR: begin
                    if (accept) begin
                        descriptor_count <= descriptor_count + 1'b1;
                        if (in_last) begin
                            state <= CAPTURE_HOLD;  // Empty payload
                        end else if (descriptor_count == 4'(DESCRIPTOR_BYTES - 1)) begin
                            state <= CAPTURE_PAYLOAD;
                        end
                    end
                end
                CAPTURE_PAYLOAD: begin
                    if (accept) begin
                        if (write_enable) begin
                            length <= length + 1'b1;
                        end
                        if (in_last) begin
                            state <= CAPTURE_HOLD;
                        end
                    end
                end
                CAPTURE_HOLD: begin
                    // Fields stay put until the generator is finished
                    if (frame_done) begin
                        state            <= CAPTURE_DESCRIPTOR;
                        descriptor_count <= '0;
                        length           <= '0;
                    end
                end
                default: state <= CAPTURE_DESCRIPTOR;
            endcase
        end
    end

endmodule

// ==== rtl/udp_tx_pkg.sv ====
// UDP transmit port definitions
package udp_tx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] udp_port_t;

    localparam int MAX_PAYLOAD = 64;

    typedef logic [5:0] payload_addr_t;
    typedef logic [6:0] payload_len_t;     // 0 to 64

    localparam int DESCRIPTOR_BYTES = 12;  // MAC, IPv4, port
    localparam int HEADER_BYTES     = 42;  // Ethernet 14, IPv4 20, UDP 8
    localparam int MIN_FRAME_BYTES  = 60;  // Without FCS

    ////////////////////////////////////////
    // Protocol constants
    ////////////////////////////////////////
    localparam logic [15:0] ETHERTYPE_IPV4    = 16'h0800;
    localparam logic [7:0]  IPV4_TTL          = 8'd64;
    localparam logic [7:0]  IPV4_PROTOCOL_UDP = 8'd17;
    localparam logic [15:0] IPV4_FLAGS_DF     = 16'h4000;
    localparam logic [15:0] UDP_SOURCE_PORT   = 16'h0400;

    ////////////////////////////////////////
    // State machines
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        CAPTURE_DESCRIPTOR,
        CAPTURE_PAYLOAD,
        CAPTURE_HOLD
    } capture_state_e;

    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_CHECKSUM,
        GEN_HEADER,
        GEN_PAYLOAD,
        GEN_PAD,
        GEN_FCS
    } generator_state_e;

endpackage

// ==== rtl/udp_tx_port.sv ====
// UDP virtual port transmit top
module udp_tx_port (
    input  logic                   clock,
    input  logic                   rst_n,
    input  udp_tx_pkg::mac_addr_t  mac_source,
    input  udp_tx_pkg::ipv4_addr_t ipv4_source,
    input  udp_tx_pkg::byte_t      in_data,
    input  logic                   in_last,
    input  logic                   in_valid,
    output logic                   in_ready,
    output udp_tx_pkg::byte_t      tx_data,
    output logic                   tx_last,
    output logic                   tx_valid,
    input  logic                   tx_ready
);
    import udp_tx_pkg::*;

    logic          write_enable;
    payload_addr_t write_address;
    byte_t         write_data;
    payload_addr_t read_address;
    byte_t         read_data;

    logic          frame_pending;
    logic          frame_done;
    mac_addr_t     mac_destination;
    ipv4_addr_t    ipv4_destination;
    udp_port_t     udp_destination;
    payload_len_t  payload_length;

    byte_t         checksum_data;
    logic          checksum_valid;
    logic          checksum_last;
    logic [15:0]   checksum_result;
    logic          checksum_result_valid;

    byte_t         fcs_data;
    logic          fcs_data_valid;
    logic          fcs_data_last;
    logic [31:0]   fcs;
    logic          fcs_valid;

    tx_request_capture i_tx_request_capture (
        .clock            (clock),
        .rst_n            (rst_n),
        .in_data          (in_data),
        .in_last          (in_last),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .write_enable     (write_enable),
        .write_address    (write_address),
        .write_data       (write_data),
        .frame_pending    (frame_pending),
        .frame_done       (frame_done),
        .mac_destination  (mac_destination),
        .ipv4_destination (ipv4_destination),
        .udp_destination  (udp_destination),
        .payload_length   (payload_length)
    );

    payload_buffer i_payload_buffer (
        .clock         (clock),
        .write_enable  (write_enable),
        .write_address (write_address),
        .write_data    (write_data),
        .read_address  (read_address),
        .read_data     (read_data)
    );

    ipv4_checksum i_ipv4_checksum (
        .clock        (clock),
        .rst_n        (rst_n),
        .data         (checksum_data),
        .data_valid   (checksum_valid),
        .data_last    (checksum_last),
        .result       (checksum_result),
        .result_valid (checksum_result_valid)
    );

    frame_check_sequence i_frame_check_sequence (
        .clock      (clock),
        .rst_n      (rst_n),
        .data       (fcs_data),
        .data_valid (fcs_data_valid),
        .data_last  (fcs_data_last),
        .fcs        (fcs),
        .fcs_valid  (fcs_valid)
    );

    frame_generator i_frame_generator (
        .clock                 (clock),
        .rst_n                 (rst_n),
        .mac_source            (mac_source),
        .ipv4_source           (ipv4_source),
        .frame_pending         (frame_pending),
        .frame_done            (frame_done),
        .mac_destination       (mac_destination),
        .ipv4_destination      (ipv4_destination),
        .udp_destination       (udp_destination),
        .payload_length        (payload_length),
        .read_address          (read_address),
        .read_data             (read_data),
        .checksum_data         (checksum_data),
        .checksum_valid        (checksum_valid),
        .checksum_last         (checksum_last),
        .checksum_result       (checksum_result),
        .checksum_result_valid (checksum_result_valid),
        .fcs_data              (fcs_data),
        .fcs_data_valid        (fcs_data_valid),
        .fcs_data_last         (fcs_data_last),
        .fcs                   (fcs),
        .fcs_valid             (fcs_valid),
        .tx_data               (tx_data),
        .tx_last               (tx_last),
        .tx_valid              (tx_valid),
        .tx_ready              (tx_ready)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module udp_tx_port_tb -f udp_tx_port.f -o udp_tx_port_sim \
    && ./obj_dir/udp_tx_port_sim | tee /dev/stderr | grep -q "RESULT: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== udp_tx_port.f ====
rtl/udp_tx_pkg.sv
rtl/payload_buffer.sv
rtl/ipv4_checksum.sv
rtl/frame_check_sequence.sv
rtl/tx_request_capture.sv
rtl/frame_generator.sv
rtl/udp_tx_port.sv
verification/udp_tx_port_asserts.sv
verification/udp_tx_port_tb.sv

// ==== verification/udp_tx_port_asserts.sv ====
// Port handshake assertions
module udp_tx_port_asserts (
    input logic              clock,
    input logic              rst_n,
    input logic              in_ready,
    input udp_tx_pkg::byte_t tx_data,
    input logic              tx_last,
    input logic              tx_valid,
    input logic              tx_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // Stalled byte is held
    property stall_holds_data;
        @(posedge clock) disable iff (!rst_n)
            (tx_valid && !tx_ready) |=> ($stable(tx_data) && $stable(tx_last));
    endproperty

    property last_needs_valid;
        @(posedge clock) disable iff (!rst_n)
            tx_last |-> tx_valid;
    endproperty

    // Capture open, generator idle
    property reset_idle;
        @(posedge clock) !rst_n |=> (in_ready && !tx_valid);
    endproperty

    assert property (stall_holds_data) else $error("tx_data or tx_last changed while stalled");
    assert property (last_needs_valid) else $error("tx_last high without tx_valid");
    assert property (reset_idle) else $error("Port not idle during reset");

endmodule

bind udp_tx_port udp_tx_port_asserts i_udp_tx_port_asserts (
    .clock    (clock),
    .rst_n    (rst_n),
    .in_ready (in_ready),
    .tx_data  (tx_data),
    .tx_last  (tx_last),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready)
);

// ==== verification/udp_tx_port_tb.sv ====
// UDP transmit port testbench
module udp_tx_port_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import udp_tx_pkg::*;

    localparam int         NUM_ROWS    = 8;
    localparam int         MAX_REQUEST = 80;
    localparam mac_addr_t  MAC_SOURCE  = 48'h02_00_5E_10_00_01;
    localparam ipv4_addr_t IPV4_SOURCE = 32'hC0A8_0001;

    typedef struct packed {
        mac_addr_t  mac;
        ipv4_addr_t ipv4;
        udp_port_t  port;
        int         length;
        logic       back_pressure;
    } request_t;

    // Destination MAC, IPv4, port, payload length, random tx_ready
    request_t requests [NUM_ROWS] = '{
        '{48'h00_1B_21_3A_4C_5D, 32'hC0A8_0A14, 16'd5000, 20, 1'b0},
        '{48'h00_1B_21_3A_4C_5E, 32'hC0A8_0A15, 16'd5001, 1, 1'b0},
        '{48'h00_1B_21_3A_4C_5F, 32'hC0A8_0A16, 16'd5002, 0, 1'b0},   // Descriptor only
        '{48'h3C_97_0E_11_22_33, 32'h0A00_0001, 16'd53, 33, 1'b1},
        '{48'hA4_5E_60_C1_D2_E3, 32'h0A00_0002, 16'd8080, 80, 1'b0},  // Over the cap
        '{48'hA4_5E_60_C1_D2_E4, 32'h0A00_0003, 16'd8081, 64, 1'b1},
        '{48'hFF_FF_FF_FF_FF_FF, 32'hFFFF_FFFF, 16'd9, 17, 1'b0},
        '{48'h02_AA_BB_CC_DD_EE, 32'hAC10_0001, 16'hFFFF, 18, 1'b1}    // Exactly 60 bytes
    };

    logic  clock;
    logic  rst_n;
    byte_t in_data;
    logic  in_last;
    logic  in_valid;
    logic  in_ready;
    byte_t tx_data;
    logic  tx_last;
    logic  tx_valid;
    logic  tx_ready;

    int    seed;
    int    cycle_count;
    byte_t payloads [NUM_ROWS][MAX_REQUEST];

    udp_tx_port i_udp_tx_port (
        .clock       (clock),
        .rst_n       (rst_n),
        .mac_source  (MAC_SOURCE),
        .ipv4_source (IPV4_SOURCE),
        .in_data     (in_data),
        .in_last     (in_last),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .tx_data     (tx_data),
        .tx_last     (tx_last),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    task automatic push_bytes(ref byte_t bytes[$], input logic [47:0] value, input int count);
        for (int i = count - 1; i >= 0; i--) begin
            bytes.push_back(value[8*i +: 8]);  // MSB first
        end
    endtask

    function automatic logic [15:0] internet_checksum(input byte_t bytes[$], input int first,
                                                      input int count);
        logic [31:0] total;
        total = '0;
        for (int i = 0; i < count; i += 2) begin
            total = total + 32'({bytes[first + i], bytes[first + i + 1]});
        end
        while (total[31:16] != '0) begin
            total = 32'(total[15:0]) + 32'(total[31:16]);
        end
        return ~total[15:0];
    endfunction

    // Bitwise reflected CRC-32, polynomial 0x04C11DB7
    function automatic logic [31:0] crc32(input byte_t bytes[$]);
        logic [31:0] crc;
        crc = 32'hFFFF_FFFF;
        foreach (bytes[n]) begin
            for (int b = 0; b < 8; b++) begin
                if (crc[0] ^ bytes[n][b]) begin
                    crc = (crc >> 1) ^ 32'hEDB8_8320;
                end else begin
                    crc = crc >> 1;
                end
            end
        end
        return ~crc;
    endfunction

    task automatic build_frame(input int row, input logic [15:0] identification,
                               output byte_t frame[$]);
        byte_t       bytes[$];
        int          kept;
        logic [15:0] checksum;
        logic [31:0] crc;
        kept = (requests[row].length > MAX_PAYLOAD) ? MAX_PAYLOAD : requests[row].length;
        push_bytes(bytes, requests[row].mac, 6);
        push_bytes(bytes, MAC_SOURCE, 6);
        push_bytes(bytes, 48'h0800, 2);
        // IPv4 header, checksum field zero until computed
        push_bytes(bytes, 48'h4500, 2);
        push_bytes(bytes, 48'(28 + kept), 2);
        push_bytes(bytes, 48'(identification), 2);
        push_bytes(bytes, 48'h4000, 2);  // DF
        push_bytes(bytes, 48'h4011, 2);  // TTL 64, UDP
        push_bytes(bytes, 48'h0, 2);
        push_bytes(bytes, 48'(IPV4_SOURCE), 4);
        push_bytes(bytes, 48'(requests[row].ipv4), 4);
        push_bytes(bytes, 48'h0400, 2);
        push_bytes(bytes, 48'(requests[row].port), 2);
        push_bytes(bytes, 48'(8 + kept), 2);
        push_bytes(bytes, 48'h0, 2);     // UDP checksum unused
        checksum  = internet_checksum(bytes, 14, 20);
        bytes[24] = checksum[15:8];
        bytes[25] = checksum[7:0];
        for (int i = 0; i < kept; i++) begin
            bytes.push_back(payloads[row][i]);
        end
        while (bytes.size() < MIN_FRAME_BYTES) begin
            bytes.push_back(8'h00);
        end
        crc = crc32(bytes);
        for (int i = 0; i < 4; i++) begin
            bytes.push_back(crc[8*i +: 8]);  // FCS goes LSB first
        end
        frame = bytes;
    endtask

    ////////////////////////////////////////
    // Drive and check
    ////////////////////////////////////////
    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %0h, actual %0h", test_name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Output differs from the reference model");
        end
    endtask

    task automatic send_request(input int row);
        byte_t bytes[$];
        push_bytes(bytes, requests[row].mac, 6);
        push_bytes(bytes, 48'(requests[row].ipv4), 4);
        push_bytes(bytes, 48'(requests[row].port), 2);
        for (int i = 0; i < requests[row].length; i++) begin
            bytes.push_back(payloads[row][i]);
        end
        foreach (bytes[i]) begin
            @(posedge clock);
            in_data  <= bytes[i];
            in_last  <= (i == bytes.size() - 1);
            in_valid <= 1'b1;
            @(negedge clock);
            while (!in_ready) @(negedge clock);  // Held until accepted
        end
        @(posedge clock);
        in_valid <= 1'b0;
        in_last  <= 1'b0;
    endtask

    task automatic receive_frame(input int row);
        byte_t expected[$];
        int    index;
        int    r;
        build_frame(row, 16'(row), expected);
        index = 0;
        while (index < expected.size()) begin
            @(posedge clock);
            r = $random(seed);
            tx_ready <= requests[row].back_pressure ? r[0] : 1'b1;
            @(negedge clock);
            if (tx_valid && tx_ready) begin
                check_value($sformatf("frame %0d byte %0d", row, index),
                            32'(expected[index]), 32'(tx_data));
                check_value($sformatf("frame %0d last flag at byte %0d", row, index),
                            32'(index == expected.size() - 1), 32'(tx_last));
                index++;
            end
        end
    endtask

    function automatic int timeout_limit();
        int total;
        total = 16;
        foreach (requests[i]) begin
            total += (12 + requests[i].length + 130) * (requests[i].back_pressure ? 2 : 1);
        end
        return total;
    endfunction

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clock);
            cycle_count++;
            if (cycle_count > timeout_limit()) begin
                $display("TIMEOUT: frames not complete after %0d cycles", cycle_count);
                $display("RESULT: FAIL");
                $fatal(1, "Simulation timed out");
            end
        end
    end

    initial begin
        int r;
        rst_n    = 1'b0;
        in_data  = '0;
        in_last  = 1'b0;
        in_valid = 1'b0;
        tx_ready = 1'b0;
        seed     = 32'h608c;
        foreach (payloads[row, i]) begin
            r = $random(seed);
            payloads[row][i] = r[7:0];
        end
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        @(posedge clock);
        fork
            begin
                for (int row = 0; row < NUM_ROWS; row++) begin
                    send_request(row);
                end
            end
            begin
                for (int row = 0; row < NUM_ROWS; row++) begin
                    receive_frame(row);
                end
            end
        join
        repeat (2) @(negedge clock);
        check_value("idle in_ready", 32'(1'b1), 32'(in_ready));
        check_value("idle tx_valid", 32'(1'b0), 32'(tx_valid));
        $display("RESULT: PASS");
        $finish;
    end

endmodule
